/* source/fir_pkg.sv */
// FIR shared definitions
package fir_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Sample and coefficient width
  localparam int data_w = 16;
  // Tap address, up to 16 taps
  localparam int tap_aw = 4;
  // Sample address, up to 64 samples
  localparam int smp_aw = 6;
  // Full product plus growth for 16 summed terms
  localparam int acc_w  = 2 * data_w + tap_aw;

  ////////////////////
  // Bundles
  ////////////////////

  // Run configuration, held by host from start to done
  typedef struct packed {
    logic [tap_aw:0] tap_num;
    logic [smp_aw:0] smp_num;
  } fir_cfg_t;

  // One host write, coef RAM uses low tap_aw address bits
  typedef struct packed {
    logic              en;
    logic [smp_aw-1:0] addr;
    logic [data_w-1:0] data;
  } ram_wr_t;

  // One output stream beat
  typedef struct packed {
    logic [acc_w-1:0] data;
    logic             last;
  } fir_beat_t;

endpackage

/* source/fir_coef_ram.sv */
// FIR coefficient memory
`timescale 1ns/10ps

module fir_coef_ram #(
  parameter int COEF_DEPTH = 16
) (
  input  logic                         clk,
  // Host write port
  input  fir_pkg::ram_wr_t             wr,
  // Core read port
  input  logic                         rd_en,
  input  logic [fir_pkg::tap_aw-1:0]   rd_addr,
  output logic [fir_pkg::data_w-1:0]   rd_data
);
  import fir_pkg::*;

  // Storage, one word per tap
  logic [data_w-1:0] mem [COEF_DEPTH];

  // Host write, only low address bits select a tap
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr[tap_aw-1:0]] <= wr.data;
    end
  end

  // Registered read
  // Output keeps last word while rd_en is low
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // Host must stay inside the coefficient table
  a_wr_range: assert property (@(posedge clk) wr.en |-> (wr.addr < COEF_DEPTH))
    else $error("coef write address %0d out of range", wr.addr);

endmodule

/* source/fir_sample_ram.sv */
// FIR sample memory
`timescale 1ns/10ps

module fir_sample_ram #(
  parameter int SAMPLE_DEPTH = 64
) (
  input  logic                         clk,
  // Host write port
  input  fir_pkg::ram_wr_t             wr,
  // Core read port
  input  logic                         rd_en,
  input  logic [fir_pkg::smp_aw-1:0]   rd_addr,
  output logic [fir_pkg::data_w-1:0]   rd_data
);
  import fir_pkg::*;

  // Storage, one word per input sample
  logic [data_w-1:0] mem [SAMPLE_DEPTH];

  // Host write, full address used
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Registered read
  // Stalled core drops rd_en so data stays put
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // Host must stay inside the sample table
  a_wr_range: assert property (@(posedge clk) wr.en |-> (wr.addr < SAMPLE_DEPTH))
    else $error("sample write address %0d out of range", wr.addr);

endmodule

/* source/fir_mult_pipe.sv */
// FIR two stage multiplier
`timescale 1ns/10ps

module fir_mult_pipe (
  input  logic                           clk,
  input  logic                           rst_n,
  // Operands, signed two's complement
  input  logic [fir_pkg::data_w-1:0]     a,
  input  logic [fir_pkg::data_w-1:0]     b,
  input  logic                           in_valid,
  // Freeze both stages
  input  logic                           hold,
  output logic [2*fir_pkg::data_w-1:0]   prod,
  output logic                           out_valid
);
  import fir_pkg::*;

  ////////////////////
  // Stage 1 operands
  ////////////////////
  logic signed [data_w-1:0] a_q;
  logic signed [data_w-1:0] b_q;
  logic                     v1_q;

  // Valid bits advance only when not held
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v1_q      <= 1'b0;
      out_valid <= 1'b0;
    end else if (!hold) begin
      v1_q      <= in_valid;
      out_valid <= v1_q;
    end
  end

  ////////////////////
  // Stage 2 product
  ////////////////////
  always_ff @(posedge clk) begin
    if (!hold) begin
      // Operands only captured for real work
      if (in_valid) begin
        a_q <= $signed(a);
        b_q <= $signed(b);
      end
      // Signed 16x16, sign extends into full width
      if (v1_q) begin
        prod <= a_q * b_q;
      end
    end
  end

  // Two advancing cycles in a row means output mirrors input from two back
  a_depth: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(!hold) && $past(!hold, 2)) |-> (out_valid == $past(in_valid, 2)))
    else $error("multiplier valid out of step with input");

endmodule

/* source/fir_main.sv */
// FIR filter core
`timescale 1ns/10ps

module fir_main #(
  parameter int COEF_DEPTH   = 16,
  parameter int SAMPLE_DEPTH = 64
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // Run control
  input  logic                           start,
  input  fir_pkg::fir_cfg_t              cfg,
  output logic                           busy,
  output logic                           done,
  // Coefficient RAM read port
  output logic                           coef_rd_en,
  output logic [fir_pkg::tap_aw-1:0]     coef_rd_addr,
  input  logic [fir_pkg::data_w-1:0]     coef_rd,
  // Sample RAM read port
  output logic                           smp_rd_en,
  output logic [fir_pkg::smp_aw-1:0]     smp_rd_addr,
  input  logic [fir_pkg::data_w-1:0]     smp_rd,
  // Multiplier
  output logic [fir_pkg::data_w-1:0]     mul_a,
  output logic [fir_pkg::data_w-1:0]     mul_b,
  output logic                           mul_in_valid,
  output logic                           mul_hold,
  input  logic [2*fir_pkg::data_w-1:0]   mul_prod,
  input  logic                           mul_out_valid,
  // Output stream
  output logic                           m_valid,
  input  logic                           m_ready,
  output fir_pkg::fir_beat_t             m_beat
);
  import fir_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_clear,
    st_calc
  } state_t;

  // Per product markers, delayed alongside the multiplier
  typedef struct packed {
    logic first;
    logic last_tap;
    logic last_smp;
  } tag_t;

  state_t            state;
  state_t            state_nxt;
  logic              hold;
  logic              issuing;
  logic              sweep_end;
  logic [tap_aw-1:0] clr_cnt;
  logic              clr_end;
  logic [tap_aw:0]   tap_cnt;
  logic [smp_aw:0]   smp_cnt;
  logic [tap_aw-1:0] tap_k;
  logic              dly_shift;
  logic [data_w-1:0] dly [COEF_DEPTH];
  tag_t              tag_d;
  tag_t              tag_q1;
  tag_t              tag_q2;
  logic [acc_w-1:0]  prod_ext;
  logic [acc_w-1:0]  acc_q;
  logic [acc_w-1:0]  acc_sum;
  logic              acc_adv;
  logic              beat_load;

  ////////////////////
  // Handshake and FSM
  ////////////////////

  // Output register full and not taken, whole datapath stalls
  assign hold     = m_valid && !m_ready;
  assign mul_hold = hold;
  // End of run is the transfer of the last beat
  assign done     = m_valid && m_ready && m_beat.last;
  assign busy     = (state != st_idle);
  assign clr_end  = (clr_cnt == tap_aw'(COEF_DEPTH - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:  if (start) state_nxt = st_clear;
      st_clear: if (clr_end) state_nxt = st_calc;
      st_calc:  if (done) state_nxt = st_idle;
      default:  state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////
  // Counters
  ////////////////////

  // One zero shifted into the delay line per clear cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clr_cnt <= '0;
    end else if (state == st_clear) begin
      clr_cnt <= clr_cnt + 1'b1;
    end else begin
      clr_cnt <= '0;
    end
  end

  // Reads stop once every sample is issued, then wait for the drain
  assign issuing   = (state == st_calc) && (smp_cnt != cfg.smp_num);
  // Sweep is tap_num + 1 cycles, slot 0 fetches the new sample
  assign sweep_end = (tap_cnt == cfg.tap_num);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tap_cnt <= '0;
      smp_cnt <= '0;
    end else if (state != st_calc) begin
      tap_cnt <= '0;
      smp_cnt <= '0;
    end else if (issuing && !hold) begin
      if (sweep_end) begin
        tap_cnt <= '0;
        smp_cnt <= smp_cnt + 1'b1;
      end else begin
        tap_cnt <= tap_cnt + 1'b1;
      end
    end
  end

  // RAM enables drop in a stall so read data stays valid
  assign coef_rd_en   = issuing && (tap_cnt < cfg.tap_num) && !hold;
  assign coef_rd_addr = tap_cnt[tap_aw-1:0];
  assign smp_rd_en    = issuing && (tap_cnt == '0) && !hold;
  assign smp_rd_addr  = smp_cnt[smp_aw-1:0];

  ////////////////////
  // Delay line
  ////////////////////

  // New sample lands in slot 1, the same cycle tap 0 uses it
  assign dly_shift = (state == st_clear) || (issuing && !hold && (tap_cnt == 1));

  always_ff @(posedge clk) begin
    if (dly_shift) begin
      dly[0] <= (state == st_clear) ? '0 : smp_rd;
      for (int i = 1; i < COEF_DEPTH; i++) begin
        dly[i] <= dly[i-1];
      end
    end
  end

  // Tap k is handled in slot k + 1
  assign tap_k        = tap_aw'(tap_cnt - 1'b1);
  assign mul_a        = coef_rd;
  // Tap 0 bypasses the line since x[n] is not shifted in yet
  assign mul_b        = (tap_cnt == 1) ? smp_rd : dly[tap_k];
  assign mul_in_valid = issuing && (tap_cnt != '0);

  ////////////////////
  // Product markers
  ////////////////////
  assign tag_d.first    = (tap_cnt == 1);
  assign tag_d.last_tap = sweep_end;
  assign tag_d.last_smp = ((smp_cnt + 1'b1) == cfg.smp_num);

  // Two stages, matching the multiplier depth
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_q1 <= '0;
      tag_q2 <= '0;
    end else if (!hold) begin
      tag_q1 <= tag_d;
      tag_q2 <= tag_q1;
    end
  end

  ////////////////////
  // Accumulator and output
  ////////////////////
  assign prod_ext  = {{tap_aw{mul_prod[2*data_w-1]}}, mul_prod};
  // First product of a sample restarts the sum
  assign acc_sum   = (tag_q2.first ? '0 : acc_q) + prod_ext;
  assign acc_adv   = mul_out_valid && !hold;
  assign beat_load = acc_adv && tag_q2.last_tap;

  always_ff @(posedge clk) begin
    if (acc_adv) begin
      acc_q <= acc_sum;
    end
    if (beat_load) begin
      m_beat.data <= acc_sum;
      m_beat.last <= tag_q2.last_smp;
    end
  end

  // Not held means empty or transferring, so refill or go empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else if (!hold) begin
      m_valid <= beat_load;
    end
  end

  // Host config must fit the RAMs when a run is accepted
  a_cfg_range: assert property (@(posedge clk) disable iff (!rst_n)
    (start && state == st_idle) |->
      (cfg.tap_num != 0 && cfg.tap_num <= COEF_DEPTH &&
       cfg.smp_num != 0 && cfg.smp_num <= SAMPLE_DEPTH))
    else $error("cfg out of range at start");

  // Stream rule, beat waits unchanged for the sink
  a_beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
    else $error("m_beat changed while stalled");

endmodule

/* source/fir_top.sv */
// FIR stream subsystem
`timescale 1ns/10ps

module fir_top #(
  parameter int COEF_DEPTH   = 16,
  parameter int SAMPLE_DEPTH = 64
) (
  input  logic               clk,
  input  logic               rst_n,
  // Host writes
  input  fir_pkg::ram_wr_t   coef_wr,
  input  fir_pkg::ram_wr_t   smp_wr,
  // Run control
  input  fir_pkg::fir_cfg_t  cfg,
  input  logic               start,
  output logic               busy,
  output logic               done,
  // Result stream
  output logic               m_valid,
  input  logic               m_ready,
  output fir_pkg::fir_beat_t m_beat
);
  import fir_pkg::*;

  // RAM read side
  logic                coef_rd_en;
  logic [tap_aw-1:0]   coef_rd_addr;
  logic [data_w-1:0]   coef_rd;
  logic                smp_rd_en;
  logic [smp_aw-1:0]   smp_rd_addr;
  logic [data_w-1:0]   smp_rd;

  // Multiplier side
  logic [data_w-1:0]   mul_a;
  logic [data_w-1:0]   mul_b;
  logic                mul_in_valid;
  logic                mul_hold;
  logic [2*data_w-1:0] mul_prod;
  logic                mul_out_valid;

  fir_coef_ram #(.COEF_DEPTH(COEF_DEPTH)) u_coef_ram (
    .clk(clk), .wr(coef_wr), .rd_en(coef_rd_en), .rd_addr(coef_rd_addr), .rd_data(coef_rd)
  );

  fir_sample_ram #(.SAMPLE_DEPTH(SAMPLE_DEPTH)) u_sample_ram (
    .clk(clk), .wr(smp_wr), .rd_en(smp_rd_en), .rd_addr(smp_rd_addr), .rd_data(smp_rd)
  );

  fir_main #(.COEF_DEPTH(COEF_DEPTH), .SAMPLE_DEPTH(SAMPLE_DEPTH)) u_main (
    .clk(clk), .rst_n(rst_n), .start(start), .cfg(cfg), .busy(busy), .done(done),
    .coef_rd_en(coef_rd_en), .coef_rd_addr(coef_rd_addr), .coef_rd(coef_rd),
    .smp_rd_en(smp_rd_en), .smp_rd_addr(smp_rd_addr), .smp_rd(smp_rd),
    .mul_a(mul_a), .mul_b(mul_b), .mul_in_valid(mul_in_valid), .mul_hold(mul_hold),
    .mul_prod(mul_prod), .mul_out_valid(mul_out_valid),
    .m_valid(m_valid), .m_ready(m_ready), .m_beat(m_beat)
  );

  fir_mult_pipe u_mult (
    .clk(clk), .rst_n(rst_n), .a(mul_a), .b(mul_b), .in_valid(mul_in_valid),
    .hold(mul_hold), .prod(mul_prod), .out_valid(mul_out_valid)
  );

endmodule

/* verif/fir_tb.sv */
// FIR stream testbench
`timescale 1ns/10ps

module fir_tb;
  import fir_pkg::*;

  localparam int coef_depth   = 16;
  localparam int sample_depth = 64;
  localparam int runs         = 6;
  // Up to 64 samples of 18 cycles per run and a margin of 4 for stalls
  localparam int max_cycles   = runs * 64 * 18 * 4;

  logic      clk;
  logic      rst_n;
  ram_wr_t   coef_wr;
  ram_wr_t   smp_wr;
  fir_cfg_t  cfg;
  logic      start;
  logic      busy;
  logic      done;
  logic      m_valid;
  logic      m_ready;
  fir_beat_t m_beat;

  // Reference model state
  logic signed [data_w-1:0] coef_mem [coef_depth];
  logic signed [data_w-1:0] smp_mem  [sample_depth];
  logic [acc_w-1:0]         exp_y    [sample_depth];

  // Run tracking for the stream sink
  integer    seed;
  int        cycles;
  int        cur_smp;
  int        beat_cnt;
  bit        run_on;
  bit        ready_rand;
  bit        stall_prev;
  fir_beat_t stall_beat;

  fir_top #(.COEF_DEPTH(coef_depth), .SAMPLE_DEPTH(sample_depth)) uut (
    .clk(clk), .rst_n(rst_n), .coef_wr(coef_wr), .smp_wr(smp_wr), .cfg(cfg),
    .start(start), .busy(busy), .done(done),
    .m_valid(m_valid), .m_ready(m_ready), .m_beat(m_beat)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Run length guard
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Simulation finished: FAIL");
      $fatal(1, "Timeout: the run did not end within %0d cycles", max_cycles);
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input logic [63:0] got, input logic [63:0] want,
                             input string msg);
    if (got !== want) begin
      $display("FAIL at %0t ns: %s, got %0h expected %0h", $time, msg, got, want);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Sink and monitor sample at the falling edge where all is settled
  task automatic observe_outputs();
    if (!run_on) begin
      check_value(busy, 1'b0, "busy while idle");
      check_value(done, 1'b0, "done while idle");
      check_value(m_valid, 1'b0, "m_valid while idle");
    end else begin
      check_value(busy, 1'b1, "busy during run");
      // Stalled beat must not move
      if (stall_prev) begin
        check_value(m_valid, 1'b1, "m_valid dropped in stall");
        check_value(m_beat, stall_beat, "m_beat changed in stall");
      end
      stall_prev = m_valid && !m_ready;
      stall_beat = m_beat;
      if (m_valid && m_ready) begin
        check_value(m_beat.data, exp_y[beat_cnt], $sformatf("y[%0d]", beat_cnt));
        check_value(m_beat.last, beat_cnt == cur_smp - 1, "last flag");
        check_value(done, beat_cnt == cur_smp - 1, "done pulse");
        // Busy must be low from the next cycle on
        if (beat_cnt == cur_smp - 1) begin
          run_on = 1'b0;
        end
        beat_cnt = beat_cnt + 1;
      end else begin
        check_value(done, 1'b0, "done without transfer");
      end
    end
  endtask

  // Observe, then move to 2 ns after the next rising edge
  task automatic next_cycle();
    @(negedge clk);
    observe_outputs();
    @(posedge clk);
    #2;
    if (ready_rand) begin
      m_ready = (($random(seed) & 32'h1) != 0);
    end else begin
      m_ready = 1'b1;
    end
  endtask

  // Fresh random coefficients and samples through the host ports
  task automatic load_memories();
    logic [data_w-1:0] d;
    for (int i = 0; i < sample_depth; i++) begin
      d = $random(seed);
      smp_mem[i] = d;
      smp_wr = '{en: 1'b1, addr: i[smp_aw-1:0], data: d};
      coef_wr.en = 1'b0;
      if (i < coef_depth) begin
        d = $random(seed);
        coef_mem[i] = d;
        coef_wr = '{en: 1'b1, addr: i[smp_aw-1:0], data: d};
      end
      next_cycle();
    end
    smp_wr  = '0;
    coef_wr = '0;
  endtask

  // y[n] is the sum of h[k] x[n-k] with zero history before sample 0
  task automatic compute_expected(input int tap, input int smp);
    longint acc;
    for (int n = 0; n < smp; n++) begin
      acc = 0;
      for (int k = 0; k < tap; k++) begin
        if (n - k >= 0) begin
          acc = acc + longint'(coef_mem[k]) * longint'(smp_mem[n-k]);
        end
      end
      exp_y[n] = acc[acc_w-1:0];
    end
  endtask

  task automatic run_filter(input int tap, input int smp, input bit rand_ready);
    load_memories();
    compute_expected(tap, smp);
    ready_rand  = rand_ready;
    cfg.tap_num = tap[tap_aw:0];
    cfg.smp_num = smp[smp_aw:0];
    cur_smp     = smp;
    beat_cnt    = 0;
    stall_prev  = 1'b0;
    start = 1'b1;
    next_cycle();
    start  = 1'b0;
    run_on = 1'b1;
    check_value(busy, 1'b1, "busy after start");
    while (run_on && beat_cnt == 0) begin
      next_cycle();
    end
    // A start in mid run must not restart the core
    if (run_on) begin
      start = 1'b1;
      next_cycle();
      start = 1'b0;
    end
    while (run_on) begin
      next_cycle();
    end
    // Core stays idle once the last beat is taken
    repeat (4) next_cycle();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    int tap;
    int smp;
    seed       = 32'hf632;
    cycles     = 0;
    run_on     = 1'b0;
    ready_rand = 1'b0;
    stall_prev = 1'b0;
    rst_n      = 1'b0;
    coef_wr    = '0;
    smp_wr     = '0;
    cfg        = '0;
    start      = 1'b0;
    m_ready    = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Quiet after reset
    repeat (10) next_cycle();
    for (int r = 0; r < runs; r++) begin
      tap = ($random(seed) & 15) + 1;
      smp = ($random(seed) & 63) + 1;
      // Corner runs for the tap range
      if (r == 1) begin
        tap = 1;
      end
      if (r == 2) begin
        tap = coef_depth;
        smp = sample_depth;
      end
      run_filter(tap, smp, r >= 2);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* fir_stream.f */
source/fir_pkg.sv
source/fir_coef_ram.sv
source/fir_sample_ram.sv
source/fir_mult_pipe.sv
source/fir_main.sv
source/fir_top.sv
verif/fir_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the FIR testbench with Verilator and run it
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal \
       -f fir_stream.f --top-module fir_tb -o fir_sim \
  && ./obj_dir/fir_sim \
  || { echo "FIR simulation did not complete cleanly"; exit 1; }
